// File: Makefile
VERILATOR ?= verilator
TOP       ?= command_processor_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal

SOURCES := $(shell cat vlog.f)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) vlog.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

// File: command/command_decoder.sv
`timescale 1ns/1ps

module command_decoder (
	input  logic                      clock,
	input  logic                      reset,
	input  command_pkg::cmd_frame_t   frame,
	input  logic                      frame_strobe,
	output command_pkg::control_t     control,
	output command_pkg::status_code_t command_valid,
	output logic [7:0]                last_command
);
	import command_pkg::*;

	localparam control_t control_reset = '{regulator_12v_en: 1'b1, default: 1'b0};

	control_t     next_control;
	status_code_t next_code;
	logic         pair_known;

	// Opcode alone is not enough, each one has its own key
	always_comb
	begin
		next_control = control;
		next_code    = command_valid;
		pair_known   = 1'b0;
		case (opcode_e'(frame.opcode))
			adc_supply_off:  pair_known = (frame.key == 4'h3);
			adc_supply_on:   pair_known = (frame.key == 4'h9);
			sd_off:          pair_known = (frame.key == 4'hD);
			sd_on:           pair_known = (frame.key == 4'h7);
			main_supply_off: pair_known = (frame.key == 4'h0);
			main_supply_on:  pair_known = (frame.key == 4'hA);
			adc_off:         pair_known = (frame.key == 4'h5);
			adc_on:          pair_known = (frame.key == 4'hB);
			link_reset:      pair_known = (frame.key == 4'h9);
			idle_exit:       pair_known = (frame.key == 4'h7);
			idle_enter:      pair_known = (frame.key == 4'h3);
			nop:             pair_known = (frame.key == 4'hF);
			default:         pair_known = 1'b0;
		endcase

		case (opcode_e'(frame.opcode))
			adc_supply_off:  begin next_code = 8'd1;  next_control.regulator_3_3v_adc_en = 1'b0; end
			adc_supply_on:   begin next_code = 8'd2;  next_control.regulator_3_3v_adc_en = 1'b1; end
			sd_off:          begin next_code = 8'd3;  next_control.sd_disable = 1'b1; end
			sd_on:           begin next_code = 8'd4;  next_control.sd_disable = 1'b0; end
			main_supply_off: begin next_code = 8'd5;  next_control.regulator_12v_en = 1'b0; end
			main_supply_on:  begin next_code = 8'd6;  next_control.regulator_12v_en = 1'b1; end
			adc_off:         begin next_code = 8'd15; next_control.adc_disable = 1'b1; end
			adc_on:          begin next_code = 8'd16; next_control.adc_disable = 1'b0; end
			link_reset:      begin next_code = 8'd26; next_control.rs232_reset = 1'b1; end
			idle_exit:       begin next_code = 8'd27; next_control.system_idle = 1'b0; end
			idle_enter:      begin next_code = 8'd28; next_control.system_idle = 1'b1; end
			nop:             next_code = 8'd29;
			default:         next_code = command_valid;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			control       <= control_reset;
			command_valid <= '0;
			last_command  <= 8'h00;
		end
		else if (frame_strobe)
		begin
			last_command <= frame.opcode; // Kept even for unknown pairs
			if (pair_known)
			begin
				control       <= next_control;
				command_valid <= next_code;
			end
		end
	end

endmodule

// File: command/command_framer.sv
`timescale 1ns/1ps

module command_framer (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [7:0]              rs232_rx_byte,
	input  logic                    rs232_rx_valid,
	output command_pkg::cmd_frame_t frame,
	output logic                    frame_strobe
);
	import command_pkg::*;

	localparam int window_bits = (frame_bytes - 1) * 8;

	logic [1:0]             rx_valid_sync;
	logic [7:0]             rx_byte_reg;
	logic [window_bits-1:0] window; // Six previous bytes, oldest at the top
	logic                   rx_accept;
	logic                   frame_match;

	assign rx_accept = rx_valid_sync[0] & ~rx_valid_sync[1]; // Rising edge of rx_valid

	// Current byte closes the frame, the window holds the rest
	assign frame_match = (rx_byte_reg == frame_end) &&
		(window[47:40] == frame_head_0) &&
		(window[39:32] == frame_head_1) &&
		(window[27:24] == frame_key_low) &&
		(window[15:8] == frame_tail_0) &&
		(window[7:0] == frame_tail_1);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rx_valid_sync <= 2'b00;
			window        <= '0;
			frame_strobe  <= 1'b0;
		end
		else
		begin
			rx_valid_sync <= {rx_valid_sync[0], rs232_rx_valid};
			frame_strobe  <= rx_accept && frame_match;
			if (rx_accept)
				window <= {window[window_bits-9:0], rx_byte_reg};
		end
	end

	always_ff @(posedge clock)
	begin
		rx_byte_reg <= rs232_rx_byte;
		if (rx_accept && frame_match)
			frame <= '{key: window[31:28], opcode: window[23:16]};
	end

endmodule

// File: common/command_pkg.sv
package command_pkg;

	// Fixed bytes of the seven-byte command frame
	localparam logic [7:0] frame_head_0 = 8'h01;
	localparam logic [7:0] frame_head_1 = 8'h02;
	localparam logic [7:0] frame_tail_0 = 8'h03;
	localparam logic [7:0] frame_tail_1 = 8'h0D;
	localparam logic [7:0] frame_end    = 8'h0A;

	localparam logic [3:0] frame_key_low = 4'hD; // Low nibble of the key byte
	localparam int         frame_bytes   = 7;

	typedef enum logic [7:0] {
		adc_supply_off  = 8'h00,
		sd_off          = 8'h01,
		main_supply_off = 8'h02,
		adc_supply_on   = 8'h10,
		sd_on           = 8'h11,
		main_supply_on  = 8'h12,
		adc_off         = 8'h40,
		adc_on          = 8'h41,
		link_reset      = 8'hFA,
		idle_exit       = 8'hFB,
		idle_enter      = 8'hFC,
		nop             = 8'hFF
	} opcode_e;

	// Unknown opcodes still travel, so the field is a plain byte
	typedef struct packed {
		logic [3:0] key;
		logic [7:0] opcode;
	} cmd_frame_t;

	typedef struct packed {
		logic regulator_12v_en;
		logic regulator_3_3v_adc_en;
		logic sd_disable;
		logic adc_disable;
		logic system_idle;
		logic rs232_reset;
	} control_t;

	typedef logic [7:0] status_code_t;

endpackage

// File: common/telemetry_pkg.sv
package telemetry_pkg;

	typedef logic [31:0] adc_sample_t;
	typedef logic [23:0] event_count_t;

	// Status byte as it appears in the record
	typedef struct packed {
		logic supply_12v_good;
		logic supply_sd_good;
		logic supply_adc_good;
		logic sd_write_ready;
		logic sd_init_1;
		logic sd_init_2;
		logic adc_init;
		logic buffer_full_latch;
	} status_t;

	localparam logic [7:0] record_end = 8'h0D; // Closing byte of every record

	typedef enum logic {
		idle,
		sending
	} serializer_state_e;

endpackage

// File: rtl/command_processor.sv
`timescale 1ns/1ps

module command_processor #(
	parameter int num_channels     = 4,
	parameter int record_period_ms = 2001
) (
	input  logic                                          clock,
	input  logic                                          reset,
	input  logic [7:0]                                    rs232_rx_byte,
	input  logic                                          rs232_rx_valid,
	input  logic                                          ms_pulse,
	input  telemetry_pkg::adc_sample_t [num_channels-1:0] adc_data,
	input  logic [num_channels-1:0]                       adc_event,
	input  telemetry_pkg::status_t                        status,
	input  logic                                          rs232_buffer_full,
	output logic                                          regulator_12v_en,
	output logic                                          regulator_3_3v_adc_en,
	output logic                                          sd_disable,
	output logic                                          adc_disable,
	output logic                                          system_idle,
	output logic                                          rs232_reset,
	output command_pkg::status_code_t                     command_valid,
	output logic                                          rs232_tx_valid,
	output logic                                          rs232_buffer_write_enable,
	output logic [7:0]                                    rs232_record_byte
);
	import command_pkg::*;
	import telemetry_pkg::*;

	cmd_frame_t                       frame;
	logic                             frame_strobe;
	control_t                         control;
	logic [7:0]                       last_command;
	logic                             snapshot;
	event_count_t [num_channels-1:0]  counts;

	assign regulator_12v_en      = control.regulator_12v_en;
	assign regulator_3_3v_adc_en = control.regulator_3_3v_adc_en;
	assign sd_disable            = control.sd_disable;
	assign adc_disable           = control.adc_disable;
	assign system_idle           = control.system_idle;
	assign rs232_reset           = control.rs232_reset;

	command_framer u_framer (
		.clock, .reset, .rs232_rx_byte, .rs232_rx_valid, .frame, .frame_strobe
	);

	command_decoder u_decoder (
		.clock, .reset, .frame, .frame_strobe, .control, .command_valid, .last_command
	);

	event_counters #(.num_channels(num_channels)) u_counters (
		.clock, .reset, .adc_event, .snapshot, .counts
	);

	record_serializer #(
		.num_channels(num_channels),
		.record_period_ms(record_period_ms)
	) u_serializer (
		.clock, .reset, .ms_pulse, .adc_data, .status, .counts, .command_valid,
		.last_command, .rs232_buffer_full, .snapshot, .rs232_tx_valid,
		.rs232_buffer_write_enable, .rs232_record_byte
	);

endmodule

// File: sim/command_processor_props.sv
`timescale 1ns/1ps

module command_processor_props (
	input logic                             clock,
	input logic                             reset,
	input logic                             rs232_buffer_full,
	input logic                             rs232_tx_valid,
	input logic                             rs232_buffer_write_enable,
	input telemetry_pkg::serializer_state_e state
);
	import telemetry_pkg::*;

	// A full buffer in one cycle blocks the write registered in the next
	no_write_after_full: assert property (
		@(posedge clock) disable iff (reset)
		rs232_buffer_full |=> !rs232_buffer_write_enable
	) else $error("write enable followed a cycle with the buffer full");

	no_start_during_write: assert property (
		@(posedge clock) disable iff (reset)
		!(rs232_tx_valid && rs232_buffer_write_enable)
	) else $error("record start strobe and write enable high together");

	no_write_when_idle: assert property (
		@(posedge clock) disable iff (reset)
		(state == idle) |-> !rs232_buffer_write_enable
	) else $error("write enable high while the serializer is idle");

endmodule

// File: sim/command_processor_tb.sv
`timescale 1ns/1ps

module command_processor_tb;
	import command_pkg::*;
	import telemetry_pkg::*;

	localparam int num_channels     = 4;
	localparam int record_period_ms = 5;
	localparam int cycle_limit      = 20000; // Several times the length of all tests

	logic                            clock;
	logic                            reset;
	logic [7:0]                      rs232_rx_byte;
	logic                            rs232_rx_valid;
	logic                            ms_pulse;
	adc_sample_t [num_channels-1:0]  adc_data;
	logic [num_channels-1:0]         adc_event;
	status_t                         status;
	logic                            rs232_buffer_full;
	logic                            regulator_12v_en;
	logic                            regulator_3_3v_adc_en;
	logic                            sd_disable;
	logic                            adc_disable;
	logic                            system_idle;
	logic                            rs232_reset;
	status_code_t                    command_valid;
	logic                            rs232_tx_valid;
	logic                            rs232_buffer_write_enable;
	logic [7:0]                      rs232_record_byte;

	control_t     exp_control;
	status_code_t exp_code;
	logic [7:0]   exp_last_command;
	event_count_t exp_counts [num_channels];
	logic [7:0]   got_bytes[$];
	logic [7:0]   exp_bytes[$];
	int           ms_count;
	int           mismatch_count;
	int           failure_count;
	int           cycle_count = 0;

	command_processor #(
		.num_channels(num_channels),
		.record_period_ms(record_period_ms)
	) uut (.*);

	bind record_serializer command_processor_props u_props (
		.clock, .reset, .rs232_buffer_full, .rs232_tx_valid, .rs232_buffer_write_enable, .state
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	task automatic compare_control(input string name, input control_t got, input control_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic compare_code(input string name, input status_code_t got,
		input status_code_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			mismatch_count++;
		end
	endtask

	function automatic control_t dut_control();
		return '{regulator_12v_en, regulator_3_3v_adc_en, sd_disable, adc_disable,
			system_idle, rs232_reset};
	endfunction

	// Bit 5 is regulator_12v_en and bit 0 is rs232_reset
	// Negative index leaves control alone
	function automatic void apply_effect(input status_code_t code, input int bit_index,
		input logic value);
		exp_code = code;
		if (bit_index >= 0)
			exp_control[bit_index] = value;
	endfunction

	function automatic void model_command(input logic [3:0] key, input logic [7:0] opcode);
		exp_last_command = opcode;
		case ({key, opcode})
			12'h300: apply_effect(8'd1, 4, 1'b0);
			12'h910: apply_effect(8'd2, 4, 1'b1);
			12'hD01: apply_effect(8'd3, 3, 1'b1);
			12'h711: apply_effect(8'd4, 3, 1'b0);
			12'h002: apply_effect(8'd5, 5, 1'b0);
			12'hA12: apply_effect(8'd6, 5, 1'b1);
			12'h540: apply_effect(8'd15, 2, 1'b1);
			12'hB41: apply_effect(8'd16, 2, 1'b0);
			12'h9FA: apply_effect(8'd26, 0, 1'b1);
			12'h7FB: apply_effect(8'd27, 1, 1'b0);
			12'h3FC: apply_effect(8'd28, 1, 1'b1);
			12'hFFF: apply_effect(8'd29, -1, 1'b0);
			default: ; // Unknown pair only moves last_command
		endcase
	endfunction

	function automatic logic [55:0] build_frame(input logic [7:0] key_byte,
		input logic [7:0] opcode, input logic [7:0] tail);
		return {8'h01, 8'h02, key_byte, opcode, tail, 8'h0D, 8'h0A};
	endfunction

	task automatic check_state();
		compare_control("control outputs", dut_control(), exp_control);
		compare_code("command_valid", command_valid, exp_code);
	endtask

	task automatic send_byte(input logic [7:0] value);
		@(posedge clock);
		rs232_rx_byte  <= value;
		rs232_rx_valid <= 1'b1;
		repeat (3) @(posedge clock);
		rs232_rx_valid <= 1'b0;
		repeat (2) @(posedge clock);
	endtask

	task automatic send_frame(input logic [55:0] bytes);
		for (int i = 6; i >= 0; i--)
			send_byte(bytes[i*8 +: 8]); // Oldest byte first
		@(negedge clock);
	endtask

	task automatic pulse_ms();
		@(posedge clock);
		ms_pulse <= 1'b1;
		@(posedge clock);
		ms_pulse <= 1'b0;
		ms_count++;
	endtask

	// Timer advances on every pulse and only the pulse at zero snaps
	task automatic request_record();
		while (ms_count % record_period_ms != 0)
			pulse_ms();
		pulse_ms();
	endtask

	task automatic pulse_events(input int cycles);
		logic [num_channels-1:0] pattern;
		for (int c = 0; c < cycles; c++)
		begin
			pattern = num_channels'($urandom);
			@(posedge clock);
			adc_event <= pattern;
			for (int i = 0; i < num_channels; i++)
			begin
				if (pattern[i])
					exp_counts[i] = exp_counts[i] + 1'b1;
			end
		end
		@(posedge clock);
		adc_event <= '0;
	endtask

	task automatic collect_record(input bit stall);
		int   waited;
		int   quiet;
		int   span;
		logic full_now;
		logic full_prev;
		waited   = 0;
		quiet    = 0;
		span     = 0;
		full_now = 1'b0;
		got_bytes.delete();
		do
		begin
			@(negedge clock);
			waited++;
		end
		while (!rs232_tx_valid && waited < 8);
		if (!rs232_tx_valid)
		begin
			$display("No record start strobe seen after the ms pulse");
			failure_count++;
		end
		else
		begin
			// Record is over once a free buffer cycle brings no write
			while (quiet < 2)
			begin
				@(posedge clock);
				full_prev = full_now;
				if (stall)
				begin
					if (span == 0)
					begin
						full_now = ($urandom_range(0, 1) == 1);
						span     = $urandom_range(1, 5);
					end
					span--;
				end
				rs232_buffer_full <= full_now;
				@(negedge clock);
				if (rs232_buffer_write_enable)
				begin
					got_bytes.push_back(rs232_record_byte);
					quiet = 0;
				end
				else if (!full_prev)
					quiet++;
			end
			@(posedge clock);
			rs232_buffer_full <= 1'b0;
		end
	endtask

	task automatic check_record();
		exp_bytes.delete();
		for (int i = 0; i < num_channels; i++)
		begin
			for (int b = 3; b >= 0; b--)
				exp_bytes.push_back(adc_data[i][b*8 +: 8]);
		end
		exp_bytes.push_back(status);
		for (int i = 0; i < num_channels; i++)
		begin
			for (int b = 2; b >= 0; b--)
				exp_bytes.push_back(exp_counts[i][b*8 +: 8]);
		end
		exp_bytes.push_back(exp_last_command);
		exp_bytes.push_back(exp_code);
		exp_bytes.push_back(8'h0D);
		compare_byte("record length", 8'(got_bytes.size()), 8'(exp_bytes.size()));
		for (int i = 0; i < exp_bytes.size() && i < got_bytes.size(); i++)
			compare_byte($sformatf("rs232_record_byte[%0d]", i), got_bytes[i], exp_bytes[i]);
		foreach (exp_counts[i])
			exp_counts[i] = '0; // Snapshot cleared the counters
	endtask

	task automatic new_adc_inputs();
		@(posedge clock);
		for (int i = 0; i < num_channels; i++)
			adc_data[i] <= $urandom;
		status <= status_t'(8'($urandom));
	endtask

	task automatic test_reset();
		exp_control      = '{regulator_12v_en: 1'b1, default: 1'b0};
		exp_code         = '0;
		exp_last_command = 8'h00;
		check_state();
	endtask

	task automatic test_commands();
		logic [11:0] commands [12] = '{12'h910, 12'hD01, 12'h002, 12'h540, 12'h3FC, 12'h300,
			12'h711, 12'hA12, 12'hB41, 12'h7FB, 12'hFFF, 12'h9FA};
		foreach (commands[i])
		begin
			send_frame(build_frame({commands[i][11:8], 4'hD}, commands[i][7:0], 8'h03));
			model_command(commands[i][11:8], commands[i][7:0]);
			check_state();
		end
	endtask

	task automatic test_rejection();
		send_frame(build_frame(8'h3D, 8'hFC, 8'h04)); // Bad trailer byte
		check_state();
		send_frame(build_frame(8'h3C, 8'hFC, 8'h03)); // Bad key nibble
		check_state();
		send_frame(build_frame(8'h5D, 8'h10, 8'h03)); // Known opcode under the wrong key
		model_command(4'h5, 8'h10);
		check_state();
		send_frame(build_frame(8'h1D, 8'h77, 8'h03));
		model_command(4'h1, 8'h77);
		check_state();
		request_record();
		collect_record(1'b0);
		check_record();
	endtask

	task automatic test_record_contents();
		new_adc_inputs();
		pulse_events(40);
		request_record();
		collect_record(1'b0);
		check_record();
		request_record();
		collect_record(1'b0);
		check_record();
	endtask

	task automatic test_back_pressure();
		new_adc_inputs();
		pulse_events(20);
		request_record();
		collect_record(1'b1);
		check_record();
	endtask

	task automatic test_record_period();
		int last_pulse;
		int strobes;
		last_pulse = -1;
		strobes    = 0;
		for (int p = 0; p < 16; p++)
		begin
			pulse_ms();
			repeat (39)
			begin
				@(negedge clock);
				if (rs232_tx_valid)
				begin
					if (last_pulse >= 0)
						compare_byte("ms pulses between rs232_tx_valid strobes",
							8'(ms_count - last_pulse), 8'(record_period_ms));
					last_pulse = ms_count;
					strobes++;
				end
			end
		end
		if (strobes < 3)
		begin
			$display("Only %0d record strobes in 16 ms pulses", strobes);
			failure_count++;
		end
	endtask

	initial
	begin
		void'($urandom(32'h5a11_bcb7));
		reset             = 1'b1;
		rs232_rx_byte     = 8'h00;
		rs232_rx_valid    = 1'b0;
		ms_pulse          = 1'b0;
		adc_data          = '0;
		adc_event         = '0;
		status            = '0;
		rs232_buffer_full = 1'b0;
		ms_count          = 0;
		mismatch_count    = 0;
		failure_count     = 0;
		foreach (exp_counts[i])
			exp_counts[i] = '0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		test_reset();
		test_commands();
		test_rejection();
		test_record_contents();
		test_back_pressure();
		test_record_period();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count + failure_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: telemetry/event_counters.sv
`timescale 1ns/1ps

module event_counters #(
	parameter int num_channels = 4
) (
	input  logic                                         clock,
	input  logic                                         reset,
	input  logic [num_channels-1:0]                      adc_event,
	input  logic                                         snapshot,
	output telemetry_pkg::event_count_t [num_channels-1:0] counts
);
	import telemetry_pkg::*;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			counts <= '0;
		else if (snapshot)
			counts <= '0; // Events on this cycle are dropped
		else
		begin
			for (int i = 0; i < num_channels; i++)
			begin
				if (adc_event[i])
					counts[i] <= counts[i] + event_count_t'(1); // Wraps at 24 bits
			end
		end
	end

endmodule

// File: telemetry/record_serializer.sv
`timescale 1ns/1ps

module record_serializer #(
	parameter int num_channels     = 4,
	parameter int record_period_ms = 2001
) (
	input  logic                                           clock,
	input  logic                                           reset,
	input  logic                                           ms_pulse,
	input  telemetry_pkg::adc_sample_t  [num_channels-1:0] adc_data,
	input  telemetry_pkg::status_t                         status,
	input  telemetry_pkg::event_count_t [num_channels-1:0] counts,
	input  command_pkg::status_code_t                      command_valid,
	input  logic [7:0]                                     last_command,
	input  logic                                           rs232_buffer_full,
	output logic                                           snapshot,
	output logic                                           rs232_tx_valid,
	output logic                                           rs232_buffer_write_enable,
	output logic [7:0]                                     rs232_record_byte
);
	import telemetry_pkg::*;

	localparam int sample_bits  = $bits(adc_sample_t);
	localparam int count_bits   = $bits(event_count_t);
	localparam int record_bytes = 7 * num_channels + 4;
	localparam int record_bits  = record_bytes * 8;
	localparam int count_w      = $clog2(record_bytes + 1);
	localparam int timer_w      = $clog2(record_period_ms + 1);
	localparam int count_base   = 24; // Above last_command, command_valid, end byte
	localparam int status_base  = count_base + count_bits * num_channels;
	localparam int adc_base     = status_base + 8;

	serializer_state_e      state;
	logic [timer_w-1:0]     ms_timer;
	logic [count_w-1:0]     byte_count;
	logic [record_bits-1:0] record;
	logic [record_bits-1:0] tx_bytes;
	logic                   send_byte;

	// Channel 0 lands in the most significant slot of each group
	always_comb
	begin
		record = '0;
		for (int i = 0; i < num_channels; i++)
		begin
			record[adc_base + sample_bits * (num_channels - 1 - i) +: sample_bits] = adc_data[i];
			record[count_base + count_bits * (num_channels - 1 - i) +: count_bits] = counts[i];
		end
		record[status_base +: 8] = status;
		record[23:16]            = last_command;
		record[15:8]             = command_valid;
		record[7:0]              = record_end;
	end

	assign snapshot  = ms_pulse && (ms_timer == '0) && (byte_count == '0);
	assign send_byte = (state == sending) && (byte_count != '0) && !rs232_buffer_full;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state                     <= idle;
			ms_timer                  <= '0;
			byte_count                <= '0;
			rs232_tx_valid            <= 1'b0;
			rs232_buffer_write_enable <= 1'b0;
		end
		else
		begin
			if (ms_pulse)
				ms_timer <= (ms_timer == timer_w'(record_period_ms - 1)) ? '0 : ms_timer + 1'b1;

			rs232_tx_valid            <= snapshot;
			rs232_buffer_write_enable <= send_byte;

			if (snapshot)
			begin
				state      <= sending;
				byte_count <= count_w'(record_bytes);
			end
			else if (send_byte)
				byte_count <= byte_count - 1'b1;
			else if ((state == sending) && (byte_count == '0))
				state <= idle; // Last byte already out
		end
	end

	always_ff @(posedge clock)
	begin
		if (snapshot)
			tx_bytes <= record;
		else if (send_byte)
		begin
			rs232_record_byte <= tx_bytes[record_bits-1 -: 8];
			tx_bytes          <= {tx_bytes[record_bits-9:0], 8'h00};
		end
	end

endmodule

// File: vlog.f
common/command_pkg.sv
common/telemetry_pkg.sv
command/command_framer.sv
command/command_decoder.sv
telemetry/event_counters.sv
telemetry/record_serializer.sv
rtl/command_processor.sv
sim/command_processor_props.sv
sim/command_processor_tb.sv
